/* project.f */
hw/fifo_pkg.sv
hw/fifo_level_ctrl.sv
hw/fifo_asym_converter.sv
hw/fifo_sync.sv
hw/lane_ram.sv
hw/asym_fifo_top.sv
tests/tb_clock_gen.sv
tests/asym_fifo_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the asym_fifo testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing -f project.f --top-module asym_fifo_tb \
      -Mdir obj_dir -o asym_fifo_sim \
   && ./obj_dir/asym_fifo_sim | tee sim.log \
   && grep -q "^TEST OK$" sim.log \
   && echo "run_sim: simulation passed" \
   || { echo "run_sim: simulation failed"; exit 1; }

/* tests/asym_fifo_tb.sv */
`default_nettype none

module asym_fifo_tb;

   import fifo_pkg::*;

   localparam int CLK_PERIOD  = 100;
   localparam int RESET_CYC   = 4;
   localparam int RANDOM_CYC  = 200;
   // reset per test, then the cycles of tests 1 to 5 with their drains
   localparam int TEST_CYCLES = 5 * (RESET_CYC + 1) + 1 + 6 + 97 + 10 + (RANDOM_CYC + 18);
   localparam int MARGIN_CYC  = 100;

   logic   clk;
   logic   rst_n_i;
   logic   w_en_i;
   wbyte_t w_data_i;
   logic   w_full_o;
   logic   r_en_i;
   rword_t r_data_o;
   logic   r_empty_o;
   level_t level_o;

   // reference model
   wbyte_t model_q[$];
   rword_t hold_word;
   rword_t pend_word;
   logic   pend_valid;

   int seed = 32'hcf7195c0;
   int errors;
   int checks;
   int tests_run;
   int tests_failed;
   int err_before;

   tb_clock_gen #(.PERIOD(CLK_PERIOD)) u_clk (.clk_o(clk));

   asym_fifo_top u_asym_fifo_top (
      .clk_i    (clk),
      .rst_n_i  (rst_n_i),
      .w_en_i   (w_en_i),
      .w_data_i (w_data_i),
      .w_full_o (w_full_o),
      .r_en_i   (r_en_i),
      .r_data_o (r_data_o),
      .r_empty_o(r_empty_o),
      .level_o  (level_o)
   );

   task automatic check_word(input rword_t got, input rword_t exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_level(input level_t got, input level_t exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   // reset DUT and model, returns on a falling edge
   task automatic apply_reset();
      rst_n_i  = 1'b0;
      w_en_i   = 1'b0;
      w_data_i = '0;
      r_en_i   = 1'b0;
      repeat (RESET_CYC) @(posedge clk);
      @(negedge clk);
      rst_n_i    = 1'b1;
      model_q    = {};
      hold_word  = '0;
      pend_word  = '0;
      pend_valid = 1'b0;
   endtask

   // one clock cycle: drive on the falling edge, update the model, check everything
   task automatic step(input logic w, input wbyte_t d, input logic r);
      logic   w_acc;
      logic   r_acc;
      rword_t popped;
      w_acc  = w && (model_q.size() < FIFO_BYTES);
      r_acc  = r && (model_q.size() >= RATIO);
      popped = '0;
      w_en_i   = w;
      w_data_i = d;
      r_en_i   = r;
      @(posedge clk);
      @(negedge clk);
      // word popped one edge ago is now on r_data_o
      if (pend_valid) begin
         hold_word = pend_word;
      end
      pend_valid = r_acc;
      if (r_acc) begin
         for (int i = 0; i < RATIO; i++) begin
            popped[i*W_DATA_W +: W_DATA_W] = model_q.pop_front();
         end
         pend_word = popped;
      end
      if (w_acc) begin
         model_q.push_back(d);
      end
      check_level(level_o, level_t'(model_q.size()), "level_o");
      check_flag(r_empty_o, model_q.size() < RATIO, "r_empty_o");
      check_flag(w_full_o, model_q.size() == FIFO_BYTES, "w_full_o");
      check_word(r_data_o, hold_word, "r_data_o");
   endtask

   task automatic test_reset_state();
      check_flag(r_empty_o, 1'b1, "r_empty_o after reset");
      check_flag(w_full_o, 1'b0, "w_full_o after reset");
      check_level(level_o, level_t'(0), "level_o after reset");
      // read on an empty FIFO is ignored
      step(1'b0, '0, 1'b1);
      check_flag(r_empty_o, 1'b1, "r_empty_o after empty read");
      check_level(level_o, level_t'(0), "level_o after empty read");
   endtask

   task automatic test_word_packing();
      wbyte_t b[RATIO];
      for (int i = 0; i < RATIO; i++) begin
         b[i] = wbyte_t'($random(seed));
         step(1'b1, b[i], 1'b0);
         check_level(level_o, level_t'(i + 1), "level_o while filling");
         check_flag(r_empty_o, i < RATIO - 1, "r_empty_o while filling");
      end
      step(1'b0, '0, 1'b1);
      check_level(level_o, level_t'(0), "level_o after pop");
      check_flag(r_empty_o, 1'b1, "r_empty_o after pop");
      step(1'b0, '0, 1'b0);
      check_word(r_data_o, {b[3], b[2], b[1], b[0]}, "packed word");
   endtask

   task automatic test_fill_and_drain();
      wbyte_t stream[FIFO_BYTES];
      for (int i = 0; i < FIFO_BYTES; i++) begin
         stream[i] = wbyte_t'($random(seed));
         step(1'b1, stream[i], 1'b0);
      end
      check_flag(w_full_o, 1'b1, "w_full_o when full");
      check_level(level_o, level_t'(64), "level_o when full");
      // this byte has to be dropped
      step(1'b1, ~stream[0], 1'b0);
      check_level(level_o, level_t'(64), "level_o after write on full");
      for (int n = 0; n < FIFO_BYTES / RATIO; n++) begin
         step(1'b0, '0, 1'b1);
         step(1'b0, '0, 1'b0);
         check_word(r_data_o, {stream[4*n+3], stream[4*n+2], stream[4*n+1], stream[4*n]},
                    "drained word");
      end
      check_flag(r_empty_o, 1'b1, "r_empty_o after drain");
   endtask

   task automatic test_simultaneous();
      wbyte_t b[8];
      for (int i = 0; i < 8; i++) begin
         b[i] = wbyte_t'($random(seed));
         step(1'b1, b[i], 1'b0);
      end
      step(1'b1, wbyte_t'($random(seed)), 1'b1);
      check_level(level_o, level_t'(5), "level_o after write and read");
      step(1'b0, '0, 1'b0);
      check_word(r_data_o, {b[3], b[2], b[1], b[0]}, "oldest word");
   endtask

   task automatic test_random_mix();
      logic   w;
      logic   r;
      wbyte_t d;
      for (int n = 0; n < RANDOM_CYC; n++) begin
         // writes three times as likely as reads
         w = ($random(seed) & 3) != 0;
         r = ($random(seed) & 3) == 0;
         d = wbyte_t'($random(seed));
         step(w, d, r);
      end
      while (model_q.size() >= RATIO) begin
         step(1'b0, '0, 1'b1);
      end
      step(1'b0, '0, 1'b0);
   endtask

   task automatic finish_test(input string name, input int err_start);
      tests_run++;
      if (errors == err_start) begin
         $display("%s: passed", name);
      end else begin
         tests_failed++;
         $display("%s: %0d errors", name, errors - err_start);
      end
   endtask

   initial begin
      #((TEST_CYCLES + MARGIN_CYC) * CLK_PERIOD);
      $display("watchdog: run did not finish within %0d cycles", TEST_CYCLES + MARGIN_CYC);
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      rst_n_i      = 1'b0;
      w_en_i       = 1'b0;
      w_data_i     = '0;
      r_en_i       = 1'b0;
      errors       = 0;
      checks       = 0;
      tests_run    = 0;
      tests_failed = 0;

      apply_reset();
      err_before = errors;
      test_reset_state();
      finish_test("reset_state", err_before);

      apply_reset();
      err_before = errors;
      test_word_packing();
      finish_test("word_packing", err_before);

      apply_reset();
      err_before = errors;
      test_fill_and_drain();
      finish_test("fill_and_drain", err_before);

      apply_reset();
      err_before = errors;
      test_simultaneous();
      finish_test("simultaneous", err_before);

      apply_reset();
      err_before = errors;
      test_random_mix();
      finish_test("random_mix", err_before);

      $display("tests run %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD = 100
) (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
   end

   // free running, first rising edge at half a period
   always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

/* hw/asym_fifo_top.sv */
`default_nettype none

module asym_fifo_top (
   input  logic             clk_i,
   input  logic             rst_n_i,

   // write side
   input  logic             w_en_i,
   input  fifo_pkg::wbyte_t w_data_i,
   output logic             w_full_o,

   // read side
   input  logic             r_en_i,
   output fifo_pkg::rword_t r_data_o,
   output logic             r_empty_o,

   output fifo_pkg::level_t level_o
);

   import fifo_pkg::*;

   lane_mask_t mem_w_en;
   mem_addr_t  mem_w_addr;
   rword_t     mem_w_data;
   lane_mask_t mem_r_en;
   mem_addr_t  mem_r_addr;
   rword_t     mem_r_data;

   fifo_sync u_fifo_sync (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .w_en_i          (w_en_i),
      .w_data_i        (w_data_i),
      .w_full_o        (w_full_o),
      .r_en_i          (r_en_i),
      .r_data_o        (r_data_o),
      .r_empty_o       (r_empty_o),
      .ext_mem_w_en_o  (mem_w_en),
      .ext_mem_w_addr_o(mem_w_addr),
      .ext_mem_w_data_o(mem_w_data),
      .ext_mem_r_en_o  (mem_r_en),
      .ext_mem_r_addr_o(mem_r_addr),
      .ext_mem_r_data_i(mem_r_data),
      .level_o         (level_o)
   );

   lane_ram u_lane_ram (
      .clk_i   (clk_i),
      .w_en_i  (mem_w_en),
      .w_addr_i(mem_w_addr),
      .w_data_i(mem_w_data),
      .r_en_i  (mem_r_en),
      .r_addr_i(mem_r_addr),
      .r_data_o(mem_r_data)
   );

endmodule

`default_nettype wire

/* hw/lane_ram.sv */
`default_nettype none

module lane_ram (
   input  logic                 clk_i,
   input  fifo_pkg::lane_mask_t w_en_i,
   input  fifo_pkg::mem_addr_t  w_addr_i,
   input  fifo_pkg::rword_t     w_data_i,
   input  fifo_pkg::lane_mask_t r_en_i,
   input  fifo_pkg::mem_addr_t  r_addr_i,
   output fifo_pkg::rword_t     r_data_o
);

   import fifo_pkg::*;

   // one word per address, split into byte lanes
   logic [RATIO-1:0][W_DATA_W-1:0] mem [2**WORD_ADDR_W];
   logic [RATIO-1:0][W_DATA_W-1:0] r_data_q;

   // each lane writes on its own enable
   always_ff @(posedge clk_i) begin
      for (int i = 0; i < RATIO; i++) begin
         if (w_en_i[i]) begin
            mem[w_addr_i][i] <= w_data_i[i*W_DATA_W +: W_DATA_W];
         end
      end
   end

   // registered read, lanes without enable keep their old byte
   always_ff @(posedge clk_i) begin
      for (int i = 0; i < RATIO; i++) begin
         if (r_en_i[i]) begin
            r_data_q[i] <= mem[r_addr_i][i];
         end
      end
   end

   assign r_data_o = r_data_q;

endmodule

`default_nettype wire

/* hw/fifo_sync.sv */
`default_nettype none

module fifo_sync (
   input  logic                 clk_i,
   input  logic                 rst_n_i,

   // write side
   input  logic                 w_en_i,
   input  fifo_pkg::wbyte_t     w_data_i,
   output logic                 w_full_o,

   // read side
   input  logic                 r_en_i,
   output fifo_pkg::rword_t     r_data_o,
   output logic                 r_empty_o,

   // external memory port
   output fifo_pkg::lane_mask_t ext_mem_w_en_o,
   output fifo_pkg::mem_addr_t  ext_mem_w_addr_o,
   output fifo_pkg::rword_t     ext_mem_w_data_o,
   output fifo_pkg::lane_mask_t ext_mem_r_en_o,
   output fifo_pkg::mem_addr_t  ext_mem_r_addr_o,
   input  fifo_pkg::rword_t     ext_mem_r_data_i,

   output fifo_pkg::level_t     level_o
);

   import fifo_pkg::*;

   logic   w_en_int;
   logic   r_en_int;
   waddr_t w_addr;
   raddr_t r_addr;

   fifo_level_ctrl u_level_ctrl (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .w_en_i    (w_en_i),
      .r_en_i    (r_en_i),
      .w_en_int_o(w_en_int),
      .r_en_int_o(r_en_int),
      .w_addr_o  (w_addr),
      .r_addr_o  (r_addr),
      .level_o   (level_o),
      .w_full_o  (w_full_o),
      .r_empty_o (r_empty_o)
   );

   // only accepted operations reach the memory
   fifo_asym_converter u_asym_converter (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .w_en_i          (w_en_int),
      .w_addr_i        (w_addr),
      .w_data_i        (w_data_i),
      .r_en_i          (r_en_int),
      .r_addr_i        (r_addr),
      .ext_mem_r_data_i(ext_mem_r_data_i),
      .ext_mem_w_en_o  (ext_mem_w_en_o),
      .ext_mem_w_addr_o(ext_mem_w_addr_o),
      .ext_mem_w_data_o(ext_mem_w_data_o),
      .ext_mem_r_en_o  (ext_mem_r_en_o),
      .ext_mem_r_addr_o(ext_mem_r_addr_o),
      .r_data_o        (r_data_o)
   );

endmodule

`default_nettype wire

/* hw/fifo_asym_converter.sv */
`default_nettype none

module fifo_asym_converter (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  logic                 w_en_i,
   input  fifo_pkg::waddr_t     w_addr_i,
   input  fifo_pkg::wbyte_t     w_data_i,
   input  logic                 r_en_i,
   input  fifo_pkg::raddr_t     r_addr_i,
   input  fifo_pkg::rword_t     ext_mem_r_data_i,
   output fifo_pkg::lane_mask_t ext_mem_w_en_o,
   output fifo_pkg::mem_addr_t  ext_mem_w_addr_o,
   output fifo_pkg::rword_t     ext_mem_w_data_o,
   output fifo_pkg::lane_mask_t ext_mem_r_en_o,
   output fifo_pkg::mem_addr_t  ext_mem_r_addr_o,
   output fifo_pkg::rword_t     r_data_o
);

   import fifo_pkg::*;

   logic [LANE_W-1:0] w_lane;
   logic              r_pending_q;
   rword_t            r_data_q;

   // low pointer bits pick the lane, upper bits the word
   assign w_lane           = w_addr_i[LANE_W-1:0];
   assign ext_mem_w_addr_o = w_addr_i[ADDR_W-1:LANE_W];

   // one-hot lane mask for the byte being written
   always_comb begin
      for (int i = 0; i < RATIO; i++) begin
         ext_mem_w_en_o[i] = w_en_i && (w_lane == LANE_W'(i));
      end
   end

   // byte copied into every lane, the mask selects the one that lands
   assign ext_mem_w_data_o = {RATIO{w_data_i}};

   // a read always takes the whole word
   assign ext_mem_r_en_o   = {RATIO{r_en_i}};
   assign ext_mem_r_addr_o = r_addr_i;

   // memory word arrives one cycle after the read, hold it until the next one
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         r_pending_q <= 1'b0;
         r_data_q    <= '0;
      end else begin
         r_pending_q <= r_en_i;
         if (r_pending_q) begin
            r_data_q <= ext_mem_r_data_i;
         end
      end
   end

   assign r_data_o = r_data_q;

endmodule

`default_nettype wire

/* hw/fifo_level_ctrl.sv */
`default_nettype none

module fifo_level_ctrl (
   input  logic             clk_i,
   input  logic             rst_n_i,
   input  logic             w_en_i,
   input  logic             r_en_i,
   output logic             w_en_int_o,
   output logic             r_en_int_o,
   output fifo_pkg::waddr_t w_addr_o,
   output fifo_pkg::raddr_t r_addr_o,
   output fifo_pkg::level_t level_o,
   output logic             w_full_o,
   output logic             r_empty_o
);

   import fifo_pkg::*;

   waddr_t w_addr_q;
   raddr_t r_addr_q;
   level_t level_q;
   level_t level_nxt;

   // accepted strobes, gated by the registered flags
   assign w_en_int_o = w_en_i & ~w_full_o;
   assign r_en_int_o = r_en_i & ~r_empty_o;

   // byte pointer and word pointer, both wrap naturally
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         w_addr_q <= '0;
         r_addr_q <= '0;
      end else begin
         if (w_en_int_o) begin
            w_addr_q <= w_addr_q + waddr_t'(1);
         end
         if (r_en_int_o) begin
            r_addr_q <= r_addr_q + raddr_t'(1);
         end
      end
   end

   assign w_addr_o = w_addr_q;
   assign r_addr_o = r_addr_q;

   // next level from the four write/read cases
   always_comb begin
      case ({w_en_int_o, r_en_int_o})
         2'b10:   level_nxt = level_q + level_t'(W_INCR);
         2'b01:   level_nxt = level_q - level_t'(R_INCR);
         2'b11:   level_nxt = level_q + level_t'(W_INCR) - level_t'(R_INCR);
         default: level_nxt = level_q;
      endcase
   end

   // level and flags all move on the accepting edge
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         level_q   <= '0;
         r_empty_o <= 1'b1;
         w_full_o  <= 1'b0;
      end else begin
         level_q   <= level_nxt;
         // not a whole word left to pop
         r_empty_o <= level_nxt < level_t'(R_INCR);
         w_full_o  <= level_nxt == level_t'(FIFO_BYTES);
      end
   end

   assign level_o = level_q;

endmodule

`default_nettype wire

/* hw/fifo_pkg.sv */
`default_nettype none

package fifo_pkg;

   // item widths on the two sides
   localparam int W_DATA_W = 8;
   localparam int R_DATA_W = 32;

   // bytes per word and the pointer bits that pick a lane
   localparam int RATIO  = R_DATA_W / W_DATA_W;
   localparam int LANE_W = 2;

   // byte pointer, word address and level widths
   localparam int ADDR_W      = 6;
   localparam int WORD_ADDR_W = ADDR_W - LANE_W;
   localparam int LEVEL_W     = ADDR_W + 1;

   // capacity in bytes
   localparam int FIFO_BYTES = 2 ** ADDR_W;

   // level change per accepted write and per accepted read
   localparam int W_INCR = 1;
   localparam int R_INCR = RATIO;

   typedef logic [W_DATA_W-1:0]    wbyte_t;
   typedef logic [R_DATA_W-1:0]    rword_t;
   typedef logic [ADDR_W-1:0]      waddr_t;
   typedef logic [WORD_ADDR_W-1:0] raddr_t;
   typedef logic [WORD_ADDR_W-1:0] mem_addr_t;
   typedef logic [RATIO-1:0]       lane_mask_t;
   typedef logic [LEVEL_W-1:0]     level_t;

endpackage

`default_nettype wire
